/* lsu_pkg.sv */
/*
 * LSU pipeline-side types for data words, byte offsets, access size,
 * load extension mode and the request bundle presented by the EX stage
 */
package lsu_pkg;

  //////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // data or address word
  typedef logic [1:0]  byte_off_t;  // byte lane inside a word

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // access size as decoded by the core
  // 2'b11 is not named and decodes as a byte access
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // load extension mode
  // 2'b11 is not named and sign extends like SEXT_SIGN
  typedef enum logic [1:0] {
    SEXT_ZERO = 2'b00,  // fill with zeros
    SEXT_SIGN = 2'b01,  // replicate msb of the loaded value
    SEXT_ONES = 2'b10   // fill with ones
  } lsu_sext_e;

  //////////////////////////////////////////////////
  // EX stage request
  //////////////////////////////////////////////////

  typedef struct packed {
    logic      we;          // store when set, load otherwise
    lsu_type_e ltype;       // word, halfword or byte
    lsu_sext_e sext;        // extension for loads
    byte_off_t reg_off;     // where the store data sits in the source register
    word_t     wdata;       // store data, unrotated
    word_t     op_a;        // address base
    word_t     op_b;        // address offset
    logic      use_incr;    // address is a + b instead of a
    logic      misaligned;  // second phase of a split access
  } lsu_req_t;

endpackage

/* lsu_bus_pkg.sv */
/*
 * LSU memory bus types for byte enables and the request and response bundles
 */
package lsu_bus_pkg;

  import lsu_pkg::*;

  typedef logic [3:0] be_t;  // one enable per byte lane

  //////////////////////////////////////////////////
  // request channel
  //////////////////////////////////////////////////

  // fields hold steady while req is high and gnt is low
  typedef struct packed {
    word_t addr;   // byte address
    logic  we;     // write enable
    be_t   be;     // active byte lanes
    word_t wdata;  // store data already rotated into its lanes
  } bus_req_t;

  //////////////////////////////////////////////////
  // response channel
  //////////////////////////////////////////////////

  // exactly one rvalid per granted request, in request order
  typedef struct packed {
    logic  rvalid;  // rdata valid this cycle
    word_t rdata;   // full read word, all lanes
  } bus_rsp_t;

endpackage

/* lsu_store_align.sv */
/*
 * LSU EX-stage request path. Forms the address, byte enables and rotated
 * write data, and flags word/halfword accesses that cross a word boundary
 */
`timescale 1ns/1ns

module lsu_store_align import lsu_pkg::*, lsu_bus_pkg::*; (
  input  lsu_req_t  ex_req_i,      // request from EX
  input  logic      ex_valid_i,    // request valid
  output bus_req_t  bus_req_o,     // address phase towards the bus
  output byte_off_t addr_off_o,    // byte offset of the unaligned address
  output logic      misaligned_o   // access needs a second phase
);

  word_t     addr_int;   // effective address before word alignment
  byte_off_t wdata_off;  // rotation of the store data
  be_t       be;
  word_t     wdata_rot;

  // base, or base plus offset
  assign addr_int   = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign addr_off_o = addr_int[1:0];

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    case (ex_req_i.ltype)
      LSU_WORD: begin
        if (!ex_req_i.misaligned) begin  // first phase covers the upper lanes
          case (addr_int[1:0])
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin                   // second phase covers the low lanes
          case (addr_int[1:0])
            2'b00:   be = 4'b0000;       // aligned words never split
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
      LSU_HALF: begin
        if (!ex_req_i.misaligned) begin
          case (addr_int[1:0])
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;       // lower byte only, upper byte follows
          endcase
        end else begin
          be = 4'b0001;                  // upper byte in lane 0 of next word
        end
      end
      default: be = 4'b0001 << addr_int[1:0];  // byte, one lane
    endcase
  end

  //////////////////////////////////////////////////
  // write data rotation
  //////////////////////////////////////////////////

  // move the data from its register lane to its memory lane
  assign wdata_off = addr_int[1:0] - ex_req_i.reg_off;

  always_comb begin
    case (wdata_off)
      2'b00:   wdata_rot = ex_req_i.wdata;
      2'b01:   wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
    endcase
  end

  // second phase always targets the next aligned word
  always_comb begin
    bus_req_o.addr  = ex_req_i.misaligned ? {addr_int[31:2], 2'b00} : addr_int;
    bus_req_o.we    = ex_req_i.we;
    bus_req_o.be    = be;
    bus_req_o.wdata = wdata_rot;
  end

  // split detection, first phase only
  always_comb begin
    misaligned_o = 1'b0;
    if (ex_valid_i && !ex_req_i.misaligned) begin
      case (ex_req_i.ltype)
        LSU_WORD: misaligned_o = (addr_int[1:0] != 2'b00);
        LSU_HALF: misaligned_o = (addr_int[1:0] == 2'b11);
        default:  misaligned_o = 1'b0;  // bytes never cross
      endcase
    end
  end

endmodule

/* lsu_load_align.sv */
/*
 * LSU WB-stage load path. Keeps the control of the access in flight, joins
 * split words and halfwords, extends the result and holds the last value
 */
`timescale 1ns/1ns

module lsu_load_align import lsu_pkg::*, lsu_bus_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ctrl_update_i,  // EX access moves to WB
  input  lsu_req_t  ex_req_i,       // request currently in EX
  input  byte_off_t addr_off_i,     // byte offset of the EX access
  input  logic      misaligned_i,   // EX access is a split first phase
  input  bus_rsp_t  bus_rsp_i,      // read response
  output word_t     ex_rdata_o      // load result
);

  // control of the access waiting for its response
  lsu_type_e type_q;
  lsu_sext_e sext_q;
  byte_off_t off_q;
  logic      we_q;

  word_t       rdata_q;    // raw first word of a split load, else last result
  word_t       rdata_w;    // word after split assembly
  logic [15:0] rdata_h;    // selected halfword
  logic [7:0]  rdata_b;    // selected byte
  word_t       rdata_ext;  // extended result

  // value of the upper fill bits for a given mode
  function automatic logic fill_bit(lsu_sext_e mode, logic msb);
    case (mode)
      SEXT_ZERO: return 1'b0;
      SEXT_ONES: return 1'b1;
      default:   return msb;  // SEXT_SIGN and the unnamed code
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      type_q <= LSU_WORD;
      sext_q <= SEXT_ZERO;
      off_q  <= '0;
      we_q   <= 1'b0;
    end else if (ctrl_update_i) begin  // granted, wait for rvalid in WB
      type_q <= ex_req_i.ltype;
      sext_q <= ex_req_i.sext;
      off_q  <= addr_off_i;
      we_q   <= ex_req_i.we;
    end
  end

  //////////////////////////////////////////////////
  // lane selection and split assembly
  //////////////////////////////////////////////////

  // low bytes of a split word come from the first response
  always_comb begin
    case (off_q)
      2'b00:   rdata_w = bus_rsp_i.rdata;
      2'b01:   rdata_w = {bus_rsp_i.rdata[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {bus_rsp_i.rdata[15:0], rdata_q[31:16]};
      default: rdata_w = {bus_rsp_i.rdata[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (off_q)
      2'b00:   rdata_h = bus_rsp_i.rdata[15:0];
      2'b01:   rdata_h = bus_rsp_i.rdata[23:8];
      2'b10:   rdata_h = bus_rsp_i.rdata[31:16];
      default: rdata_h = {bus_rsp_i.rdata[7:0], rdata_q[31:24]};  // crosses the word
    endcase
  end

  assign rdata_b = bus_rsp_i.rdata[8*off_q +: 8];

  // extension by size and mode
  always_comb begin
    case (type_q)
      LSU_WORD: rdata_ext = rdata_w;
      LSU_HALF: rdata_ext = {{16{fill_bit(sext_q, rdata_h[15])}}, rdata_h};
      default:  rdata_ext = {{24{fill_bit(sext_q, rdata_b[7])}}, rdata_b};
    endcase
  end

  // raw word while a split load is under way, finished value otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (bus_rsp_i.rvalid && !we_q) begin
      if (misaligned_i || ex_req_i.misaligned) begin
        rdata_q <= bus_rsp_i.rdata;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  assign ex_rdata_o = bus_rsp_i.rvalid ? rdata_ext : rdata_q;  // live in rvalid cycle

endmodule

/* lsu_bus_ctrl.sv */
/*
 * LSU bus control. Counts outstanding transactions, gates the bus request
 * and derives the EX/WB handshakes and the busy flag
 */
`timescale 1ns/1ns

module lsu_bus_ctrl #(
  parameter int unsigned DEPTH = 2  // max outstanding transactions
) (
  input  logic clk,
  input  logic rst_n,
  input  logic ex_valid_i,      // EX holds a load or store
  input  logic gnt_i,           // bus grant
  input  logic rvalid_i,        // bus response valid
  output logic data_req_o,      // bus request
  output logic lsu_ready_ex_o,  // EX access may leave
  output logic lsu_ready_wb_o,  // WB slot free or completing
  output logic ctrl_update_o,   // load WB control registers
  output logic busy_o           // transfers in flight or starting
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [CNT_W-1:0] cnt_t;  // outstanding count, 0..DEPTH

  cnt_t cnt_q;
  cnt_t cnt_d;
  logic accept;  // request and grant in the same cycle

  //////////////////////////////////////////////////
  // request gating
  //////////////////////////////////////////////////

  assign data_req_o = ex_valid_i && (cnt_q < DEPTH);  // no path from rvalid
  assign accept     = data_req_o && gnt_i;

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  // WB is free when empty, or when its response shows up
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : rvalid_i;

  // EX readiness
  //   no request      ready
  //   nothing out     on grant
  //   one out         grant and response together
  //   limit reached   EX access is already issued, leave on response
  assign lsu_ready_ex_o = !ex_valid_i          ? 1'b1 :
                          (cnt_q == '0)        ? accept :
                          (cnt_q == cnt_t'(1)) ? (accept && rvalid_i) :
                                                 rvalid_i;

  assign ctrl_update_o = lsu_ready_ex_o && ex_valid_i;

  assign busy_o = (cnt_q != '0) || data_req_o;

  //////////////////////////////////////////////////
  // outstanding counter
  //////////////////////////////////////////////////

  always_comb begin
    case ({accept, rvalid_i})
      2'b10:   cnt_d = cnt_q + cnt_t'(1);  // new one granted
      2'b01:   cnt_d = cnt_q - cnt_t'(1);  // one retired
      default: cnt_d = cnt_q;              // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

/* lsu_top.sv */
/*
 * LSU top level. Joins the EX request path, the bus control and the WB
 * load path between the pipeline ports and the memory bus
 */
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*, lsu_bus_pkg::*; #(
  parameter int unsigned DEPTH = 2  // max outstanding transactions
) (
  input  logic     clk,
  input  logic     rst_n,

  // pipeline side
  input  lsu_req_t ex_req_i,        // EX request
  input  logic     ex_valid_i,      // EX request valid
  output word_t    ex_rdata_o,      // load result
  output logic     misaligned_o,    // second phase needed
  output logic     lsu_ready_ex_o,
  output logic     lsu_ready_wb_o,
  output logic     busy_o,

  // memory bus
  output logic     data_req_o,
  input  logic     data_gnt_i,
  output bus_req_t bus_req_o,       // address phase
  input  bus_rsp_t bus_rsp_i        // response phase
);

  byte_off_t addr_off;     // unaligned byte offset of the EX access
  logic      ctrl_update;  // EX access hands over to WB

  //////////////////////////////////////////////////
  // EX request path
  //////////////////////////////////////////////////

  lsu_store_align store_align_inst (
    .ex_req_i     (ex_req_i),
    .ex_valid_i   (ex_valid_i),
    .bus_req_o    (bus_req_o),
    .addr_off_o   (addr_off),
    .misaligned_o (misaligned_o)
  );

  //////////////////////////////////////////////////
  // transaction control
  //////////////////////////////////////////////////

  lsu_bus_ctrl #(
    .DEPTH (DEPTH)
  ) bus_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_i),
    .gnt_i          (data_gnt_i),
    .rvalid_i       (bus_rsp_i.rvalid),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .ctrl_update_o  (ctrl_update),
    .busy_o         (busy_o)
  );

  // WB load path
  lsu_load_align load_align_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_update_i (ctrl_update),
    .ex_req_i      (ex_req_i),
    .addr_off_i    (addr_off),
    .misaligned_i  (misaligned_o),
    .bus_rsp_i     (bus_rsp_i),
    .ex_rdata_o    (ex_rdata_o)
  );

endmodule

/* lsu_chk.sv */
/*
 * LSU protocol checker. Counter bounds, bus quiet at the limit,
 * no stray responses and known request fields
 */
`timescale 1ns/1ns

module lsu_chk import lsu_pkg::*, lsu_bus_pkg::*; #(
  parameter int unsigned DEPTH = 2
) (
  input logic                         clk,
  input logic                         rst_n,
  input logic [$clog2(DEPTH+1)-1:0]   cnt_i,       // outstanding count
  input logic                         data_req_i,
  input logic                         gnt_i,
  input logic                         rvalid_i,
  input bus_req_t                     bus_req_i
);

  cnt_max: assert property (@(posedge clk) disable iff (!rst_n) cnt_i <= DEPTH)
    else $error("outstanding count above DEPTH");

  // full means no new request and no grant
  limit_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_i == DEPTH) |-> (!data_req_i && !gnt_i))
    else $error("bus activity with all slots outstanding");

  no_stray_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (cnt_i != '0))
    else $error("response with nothing outstanding");

  req_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i |-> !$isunknown(bus_req_i))
    else $error("request fields unknown while request is high");

endmodule

// counter sits inside the bus control, request fields at the top level
bind lsu_top lsu_chk #(.DEPTH(DEPTH)) chk_inst (
  .clk        (clk),
  .rst_n      (rst_n),
  .cnt_i      (bus_ctrl_inst.cnt_q),
  .data_req_i (data_req_o),
  .gnt_i      (data_gnt_i),
  .rvalid_i   (bus_rsp_i.rvalid),
  .bus_req_i  (bus_req_o)
);

/* lsu_tb.sv */
/*
 * LSU testbench. Directed loads and stores against a byte-enable memory
 * with random grant delay, checked against a byte-wise shadow image
 */
`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*, lsu_bus_pkg::*; ();

  localparam int unsigned DEPTH = 2;
  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 50;  // budget per directed test

  typedef struct packed {
    logic  care;  // first phase of a split load has no result of its own
    word_t val;
  } exp_t;

  logic     clk = 1'b0;
  logic     rst_n;
  lsu_req_t ex_req;
  logic     ex_valid;
  logic     misaligned, ready_ex, ready_wb, busy;
  logic     data_req, data_gnt;
  word_t    ex_rdata;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  word_t      mem [0:63];      // memory behind the bus
  logic [7:0] shadow [0:255];  // expected memory image
  exp_t       exp_q [$];       // expected load results, in issue order
  word_t      got_q [$];       // ex_rdata_o seen in each load rvalid cycle
  integer     seed = 85614;
  int         wait_cnt = 0;    // cycles until the next grant
  int         owed = 0;        // granted accesses still waiting for rvalid
  logic       gnt_hold;        // withhold grant completely
  logic       rsp_we;          // response on the bus belongs to a store

  lsu_top #(
    .DEPTH (DEPTH)
  ) lsu_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_req_i       (ex_req),
    .ex_valid_i     (ex_valid),
    .ex_rdata_o     (ex_rdata),
    .misaligned_o   (misaligned),
    .lsu_ready_ex_o (ready_ex),
    .lsu_ready_wb_o (ready_wb),
    .busy_o         (busy),
    .data_req_o     (data_req),
    .data_gnt_i     (data_gnt),
    .bus_req_o      (bus_req),
    .bus_rsp_i      (bus_rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////

  function automatic word_t fill_word(int idx);
    return word_t'(idx + 1) * 32'h9e37_79b1;  // every byte depends on the index
  endfunction

  function automatic lsu_req_t make_req(logic we, word_t addr, lsu_type_e t, lsu_sext_e m,
                                        word_t v);
    lsu_req_t req;
    req       = '0;
    req.we    = we;
    req.ltype = t;
    req.sext  = m;
    req.wdata = v;     // source value in the low bytes
    req.op_a  = addr;  // base only on the first phase
    return req;
  endfunction

  // lanes touched by n bytes from offset off, in the first or the next word
  function automatic be_t lane_mask(byte_off_t off, int n, logic second);
    be_t m;
    int  lane;
    m = '0;
    for (int k = 0; k < n; k++) begin
      lane = int'(off) + k;
      if (!second && lane < 4) m[lane] = 1'b1;
      if (second && lane >= 4) m[lane - 4] = 1'b1;
    end
    return m;
  endfunction

  // little-endian bytes from the image, upper bits filled per mode
  function automatic word_t expected_load(word_t addr, int n, lsu_sext_e m);
    word_t v;
    logic  fill;
    v = '0;
    for (int k = 0; k < n; k++) v[8*k +: 8] = shadow[(addr + k) & 255];
    fill = (m == SEXT_ZERO) ? 1'b0 : (m == SEXT_ONES) ? 1'b1 : v[8*n - 1];
    for (int b = 8 * n; b < 32; b++) v[b] = fill;
    return v;
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic abort_run(string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(string name, word_t act, word_t exp);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, act, exp);
      $display("*** FAILED ***");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic compare_be(string name, be_t act, be_t exp);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, act, exp);
      $display("*** FAILED ***");
      $fatal(1, "byte enable mismatch");
    end
  endtask

  task automatic compare_flag(string name, logic act, logic exp);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, act, exp);
      $display("*** FAILED ***");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_memory();
    for (int i = 0; i < 64; i++) begin
      compare_word($sformatf("mem[%0d]", i), mem[i],
                   {shadow[4*i+3], shadow[4*i+2], shadow[4*i+1], shadow[4*i]});
    end
  endtask

  task automatic check_results();
    exp_t  e;
    word_t g;
    while (exp_q.size() > 0) begin
      if (got_q.size() == 0) abort_run("a load response never arrived");
      e = exp_q.pop_front();
      g = got_q.pop_front();
      if (e.care) compare_word("ex_rdata_o", g, e.val);
    end
    if (got_q.size() != 0) abort_run("more load responses than loads issued");
  endtask

  //////////////////////////////////////////////////
  // stimulus, called at 2 ns after a rising edge
  //////////////////////////////////////////////////

  task automatic issue_access(input lsu_req_t req, output bus_req_t seen, output logic mis);
    logic first;
    first  = 1'b1;
    seen   = '0;
    ex_req   = req;
    ex_valid = 1'b1;
    do begin
      @(negedge clk);
      if (first) mis = misaligned;
      first = 1'b0;
      if (data_req && data_gnt) seen = bus_req;  // address phase accepted
    end while (!ready_ex);
    @(posedge clk);
    #2;
  endtask

  // one access, split into two phases when it crosses a word
  task automatic run_access(logic we, word_t addr, lsu_type_e t, lsu_sext_e m, word_t v);
    lsu_req_t  req;
    bus_req_t  seen;
    logic      mis;
    byte_off_t off;
    int        n;
    logic      split;
    off   = addr[1:0];
    n     = (t == LSU_WORD) ? 4 : (t == LSU_HALF) ? 2 : 1;
    split = (int'(off) + n) > 4;
    req   = make_req(we, addr, t, m, v);
    issue_access(req, seen, mis);
    compare_flag("misaligned_o", mis, split);
    compare_word("bus_req_o.addr", seen.addr, addr);
    compare_be("bus_req_o.be", seen.be, lane_mask(off, n, 1'b0));
    if (split) begin
      if (!we) exp_q.push_back({1'b0, 32'h0});
      req.misaligned = 1'b1;   // controller reissues at addr + 4
      req.op_b       = 32'd4;
      req.use_incr   = 1'b1;
      issue_access(req, seen, mis);
      compare_word("bus_req_o.addr", seen.addr, (addr + 32'd4) & ~32'd3);
      compare_be("bus_req_o.be", seen.be, lane_mask(off, n, 1'b1));
    end
    if (we) begin
      for (int k = 0; k < n; k++) shadow[(addr + k) & 255] = v[8*k +: 8];
    end else begin
      exp_q.push_back({1'b1, expected_load(addr, n, m)});
    end
  endtask

  task automatic wait_idle();
    ex_valid       = 1'b0;
    ex_req.misaligned = 1'b0;
    do @(negedge clk); while (busy);
    @(posedge clk);
    #2;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic aligned_stores();
    for (int off = 0; off < 4; off++) run_access(1'b1, 4*(4+off) + off, LSU_BYTE, SEXT_ZERO,
                                                 $random(seed));
    for (int off = 0; off < 3; off++) run_access(1'b1, 4*(10+off) + off, LSU_HALF, SEXT_ZERO,
                                                 $random(seed));
    run_access(1'b1, 4*16, LSU_WORD, SEXT_ZERO, $random(seed));
    wait_idle();
    check_memory();
  endtask

  task automatic aligned_loads();
    lsu_sext_e m;
    for (int mi = 0; mi < 3; mi++) begin
      m = lsu_sext_e'(mi);
      for (int off = 0; off < 4; off++) run_access(1'b0, 4*(20+mi) + off, LSU_BYTE, m, '0);
      for (int off = 0; off < 3; off++) run_access(1'b0, 4*(24+mi) + off, LSU_HALF, m, '0);
    end
    run_access(1'b0, 4*27, LSU_WORD, SEXT_ZERO, '0);
    wait_idle();
    check_results();
  endtask

  task automatic misaligned_loads();
    for (int off = 1; off < 4; off++) run_access(1'b0, 4*(28+2*off) + off, LSU_WORD,
                                                 SEXT_ZERO, '0);
    run_access(1'b0, 4*37 + 3, LSU_HALF, SEXT_SIGN, '0);
    run_access(1'b0, 4*37 + 3, LSU_HALF, SEXT_ZERO, '0);
    wait_idle();
    check_results();
  endtask

  task automatic misaligned_store();
    run_access(1'b1, 4*40 + 2, LSU_WORD, SEXT_ZERO, $random(seed));
    run_access(1'b1, 4*43 + 3, LSU_HALF, SEXT_ZERO, $random(seed));
    run_access(1'b1, 4*46 + 1, LSU_WORD, SEXT_ZERO, $random(seed));
    wait_idle();
    check_memory();  // neighbours must be untouched
    run_access(1'b0, 4*40 + 2, LSU_WORD, SEXT_ZERO, '0);
    run_access(1'b0, 4*43 + 3, LSU_HALF, SEXT_SIGN, '0);
    wait_idle();
    check_results();
  endtask

  task automatic stalled_burst();
    @(negedge clk);
    gnt_hold = 1'b1;
    @(posedge clk);
    #2;
    ex_req   = make_req(1'b0, 4*50, LSU_WORD, SEXT_ZERO, '0);
    ex_valid = 1'b1;
    repeat (3) begin
      @(negedge clk);
      compare_flag("busy_o", busy, 1'b1);
      compare_flag("data_req_o", data_req, 1'b1);  // request held while stalled
    end
    gnt_hold = 1'b0;
    run_access(1'b0, 4*50, LSU_WORD, SEXT_ZERO, '0);
    run_access(1'b0, 4*51 + 2, LSU_HALF, SEXT_SIGN, '0);
    run_access(1'b0, 4*54 + 3, LSU_WORD, SEXT_ZERO, '0);
    run_access(1'b0, 4*52 + 3, LSU_BYTE, SEXT_ONES, '0);
    run_access(1'b0, 4*53 + 1, LSU_BYTE, SEXT_SIGN, '0);
    wait_idle();
    check_results();
    @(negedge clk);
    compare_flag("busy_o", busy, 1'b0);
    compare_word("ex_rdata_o", ex_rdata, expected_load(4*53 + 1, 1, SEXT_SIGN));  // held
  endtask

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  always begin : memory_model
    logic  acc;
    logic  acc_we;
    word_t rd;
    int    widx;
    @(negedge clk);
    acc    = data_req && data_gnt;
    acc_we = bus_req.we;
    widx   = bus_req.addr[7:2];
    rd     = mem[widx];
    if (acc && acc_we) begin
      for (int b = 0; b < 4; b++) begin
        if (bus_req.be[b]) mem[widx][8*b +: 8] = bus_req.wdata[8*b +: 8];
      end
    end
    if (acc) wait_cnt = $unsigned($random(seed)) % 3;  // 0 to 2 cycles
    else if (data_req && wait_cnt > 0) wait_cnt--;
    if (bus_rsp.rvalid && !rsp_we) got_q.push_back(ex_rdata);
    // WB is ready with nothing owed, else only in a response cycle
    compare_flag("lsu_ready_wb_o", ready_wb, (owed == 0) || bus_rsp.rvalid);
    owed = owed + int'(acc) - int'(bus_rsp.rvalid);
    @(posedge clk);
    #2;
    bus_rsp.rvalid = acc;  // one cycle after the grant
    bus_rsp.rdata  = (acc && !acc_we) ? rd : '0;
    rsp_we         = acc_we;
    data_gnt       = !gnt_hold && (wait_cnt == 0);
  end

  initial begin : watchdog
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    ex_req   = '0;
    ex_valid = 1'b0;
    data_gnt = 1'b0;
    bus_rsp  = '0;
    gnt_hold = 1'b0;
    rsp_we   = 1'b0;
    rst_n    = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
      for (int b = 0; b < 4; b++) shadow[4*i + b] = mem[i][8*b +: 8];
    end
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    compare_flag("data_req_o", data_req, 1'b0);
    compare_flag("busy_o", busy, 1'b0);
    compare_flag("misaligned_o", misaligned, 1'b0);
    compare_flag("lsu_ready_wb_o", ready_wb, 1'b1);
    @(posedge clk);
    #2;
    aligned_stores();
    aligned_loads();
    misaligned_loads();
    misaligned_store();
    stalled_burst();
    if (exp_q.size() != 0 || got_q.size() != 0) begin
      $display("load results left unmatched at end of run");
      $display("*** FAILED ***");
      $fatal(1, "unmatched results");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

/* vlog.f */
lsu_pkg.sv
lsu_bus_pkg.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_bus_ctrl.sv
lsu_top.sv
lsu_chk.sv
lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - lsu_pkg.sv
      - lsu_bus_pkg.sv
      - lsu_store_align.sv
      - lsu_load_align.sv
      - lsu_bus_ctrl.sv
      - lsu_top.sv
  - target: test
    files:
      - lsu_chk.sv
      - lsu_tb.sv
